// File: verilog/fpu_pkg.sv
// shared definitions for the vector fp side unit
// modules import this package in their headers with a wildcard import
`default_nettype none

package fpu_pkg;

  localparam int WORD_W = 64;
  localparam int OPC_W  = 6;
  localparam int TAG_W  = 6;

  // raised flag vector and the bit index of each flag
  localparam int FLAG_W        = 2;
  localparam int FLAG_IDX_W    = $clog2(FLAG_W);
  localparam int FLAG_INVALID  = 0;
  localparam int FLAG_DENORMAL = 1;

  // lane logic, low two bits pick the operation
  localparam logic [OPC_W-1:0] OP_AND  = 6'h00;
  localparam logic [OPC_W-1:0] OP_OR   = 6'h01;
  localparam logic [OPC_W-1:0] OP_XOR  = 6'h02;
  localparam logic [OPC_W-1:0] OP_ANDN = 6'h03;

  // single lane permutes
  localparam logic [OPC_W-1:0] OP_SWAP_S  = 6'h04;
  localparam logic [OPC_W-1:0] OP_DUP_S   = 6'h05;
  localparam logic [OPC_W-1:0] OP_MERGE_S = 6'h06;

  // compares, bit 4 selects paired single and bit 5 the ordered variant
  localparam logic [OPC_W-1:0] OP_CMP_EQ = 6'h08;
  localparam logic [OPC_W-1:0] OP_CMP_LT = 6'h09;
  localparam logic [OPC_W-1:0] OP_CMP_LE = 6'h0a;
  localparam logic [OPC_W-1:0] OP_CMP_UN = 6'h0b;

  typedef enum logic [1:0] {
    CLASS_LOGIC   = 2'd0,
    CLASS_PERMUTE = 2'd1,
    CLASS_COMPARE = 2'd2
  } exec_class_e;

  // one operand word, seen as a double or as two singles (lane 0 is low)
  typedef union packed {
    struct packed {
      logic        sign;
      logic [10:0] exponent;
      logic [51:0] mantissa;
    } dbl;
    struct packed {
      logic        sign;
      logic [7:0]  exponent;
      logic [22:0] mantissa;
    } [1:0] sgl;
  } fp_word_u;

endpackage

`default_nettype wire

// File: verilog/operand_forward.sv
// picks one operand from the issue port or a result forwarding bus
// sel = 0 takes the port value, sel = k takes bus k-1
// with late set the bus value of the previous cycle is used instead
`default_nettype none

module operand_forward import fpu_pkg::*; #(
  parameter int FWD_COUNT = 4
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [WORD_W-1:0]                   port_val,
  input  logic [$clog2(FWD_COUNT + 1)-1:0]    sel,
  input  logic                                late,
  input  logic [FWD_COUNT-1:0][WORD_W-1:0]    fwd_bus,
  output logic [WORD_W-1:0]                   operand
);

  // bus values seen one cycle ago
  logic [FWD_COUNT-1:0][WORD_W-1:0] bus_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      bus_q <= '0;
    end else begin
      bus_q <= fwd_bus;
    end
  end

  // out of range selects fall through to zero
  always_comb begin
    operand = '0;
    if (sel == '0) begin
      operand = port_val;
    end
    for (int i = 0; i < FWD_COUNT; i++) begin
      if (int'(sel) == i + 1) begin
        operand = late ? bus_q[i] : fwd_bus[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/fpu_op_decode.sv
// first pipeline stage, registers the issued opcode and tag
// and turns the opcode into execution class and datapath selects
`default_nettype none

module fpu_op_decode import fpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              en,
  input  logic [OPC_W-1:0]  op,
  input  logic [TAG_W-1:0]  tag,
  output logic              valid,
  output exec_class_e       exec_class,
  output logic [1:0]        logic_sel,
  output logic [1:0]        perm_sel,
  output logic [1:0]        cmp_pred,
  output logic              cmp_paired,
  output logic              cmp_ordered,
  output logic [TAG_W-1:0]  tag_q
);

  exec_class_e class_d;
  logic [1:0]  logic_d;
  logic [1:0]  perm_d;

  // unknown opcodes run as a plain and so they still retire
  always_comb begin
    class_d = CLASS_LOGIC;
    logic_d = 2'd0;
    perm_d  = 2'd0;
    if ({2'b00, op[3:2], 2'b00} == OP_CMP_EQ) begin
      class_d = CLASS_COMPARE;
    end else begin
      case (op)
        OP_AND, OP_OR, OP_XOR, OP_ANDN: logic_d = op[1:0];
        OP_SWAP_S, OP_DUP_S, OP_MERGE_S: begin
          class_d = CLASS_PERMUTE;
          perm_d  = op[1:0];
        end
        default: logic_d = 2'd0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid       <= 1'b0;
      exec_class  <= CLASS_LOGIC;
      logic_sel   <= 2'd0;
      perm_sel    <= 2'd0;
      cmp_pred    <= 2'd0;
      cmp_paired  <= 1'b0;
      cmp_ordered <= 1'b0;
    end else begin
      valid       <= en;
      exec_class  <= class_d;
      logic_sel   <= logic_d;
      perm_sel    <= perm_d;
      cmp_pred    <= op[1:0];
      cmp_paired  <= op[4];
      cmp_ordered <= op[5];
    end
  end

  always_ff @(posedge clk) begin
    tag_q <= tag;
  end

endmodule

`default_nettype wire

// File: verilog/fpu_lane_ops.sv
// second stage datapath for bitwise lane logic and single lane permutes
// result is registered, these operations never raise flags
`default_nettype none

module fpu_lane_ops import fpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  fp_word_u          a,
  input  fp_word_u          b,
  input  exec_class_e       exec_class,
  input  logic [1:0]        logic_sel,
  input  logic [1:0]        perm_sel,
  output logic [WORD_W-1:0] res,
  output logic [FLAG_W-1:0] flags
);

  logic [WORD_W-1:0] logic_w;
  fp_word_u          perm_w;

  // and, or, xor, and-not over the full word
  always_comb begin
    case (logic_sel)
      2'd0:    logic_w = a & b;
      2'd1:    logic_w = a | b;
      2'd2:    logic_w = a ^ b;
      default: logic_w = a & ~b;
    endcase
  end

  always_comb begin
    perm_w = a;
    case (perm_sel)
      // swap the two singles of a
      2'd0: begin
        perm_w.sgl[0] = a.sgl[1];
        perm_w.sgl[1] = a.sgl[0];
      end
      // low single of b into both lanes
      2'd1: begin
        perm_w.sgl[0] = b.sgl[0];
        perm_w.sgl[1] = b.sgl[0];
      end
      // high of a over low of b
      2'd2: perm_w.sgl[0] = b.sgl[0];
      default: perm_w = a;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res <= '0;
    end else begin
      res <= (exec_class == CLASS_PERMUTE) ? perm_w : logic_w;
    end
  end

  assign flags = '0;

endmodule

`default_nettype wire

// File: verilog/fpu_compare.sv
// double and paired single compare, registered in the second stage
// each lane gives all ones when the predicate holds, else zero
// raises invalid on NaN inputs and denormal on denormal inputs
`default_nettype none

module fpu_compare import fpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  fp_word_u          a,
  input  fp_word_u          b,
  input  logic [1:0]        pred,
  input  logic              paired,
  input  logic              ordered,
  output logic [WORD_W-1:0] res,
  output logic [FLAG_W-1:0] flags
);

  logic              d_nan_a, d_nan_b, d_snan_a, d_snan_b, d_den_a, d_den_b;
  logic [1:0]        s_nan_a, s_nan_b, s_snan_a, s_snan_b, s_den_a, s_den_b;
  logic [1:0]        s_hit;
  logic              d_hit;
  logic [WORD_W-1:0] res_d;
  logic [FLAG_W-1:0] flags_d;

  // sign magnitude compare, magnitudes zero extended to the double width
  function automatic logic pred_hit(input logic sa, input logic sb, input logic [62:0] ma,
                                    input logic [62:0] mb, input logic unord,
                                    input logic [1:0] p);
    logic both_zero;
    logic eq;
    logic lt;
    both_zero = (ma == '0) && (mb == '0);
    eq = both_zero || ((sa == sb) && (ma == mb));
    if (both_zero) lt = 1'b0;
    else if (sa != sb) lt = sa;
    else lt = sa ? (ma > mb) : (ma < mb);
    case (p)
      2'd0:    return eq & ~unord;
      2'd1:    return lt & ~unord;
      2'd2:    return (lt | eq) & ~unord;
      default: return unord;
    endcase
  endfunction

  always_comb begin
    d_nan_a  = (&a.dbl.exponent) && (|a.dbl.mantissa);
    d_nan_b  = (&b.dbl.exponent) && (|b.dbl.mantissa);
    d_snan_a = d_nan_a && !a.dbl.mantissa[51];
    d_snan_b = d_nan_b && !b.dbl.mantissa[51];
    d_den_a  = (~|a.dbl.exponent) && (|a.dbl.mantissa);
    d_den_b  = (~|b.dbl.exponent) && (|b.dbl.mantissa);
    d_hit = pred_hit(a.dbl.sign, b.dbl.sign, {a.dbl.exponent, a.dbl.mantissa},
                     {b.dbl.exponent, b.dbl.mantissa}, d_nan_a | d_nan_b, pred);
    for (int l = 0; l < 2; l++) begin
      s_nan_a[l]  = (&a.sgl[l].exponent) && (|a.sgl[l].mantissa);
      s_nan_b[l]  = (&b.sgl[l].exponent) && (|b.sgl[l].mantissa);
      s_snan_a[l] = s_nan_a[l] && !a.sgl[l].mantissa[22];
      s_snan_b[l] = s_nan_b[l] && !b.sgl[l].mantissa[22];
      s_den_a[l]  = (~|a.sgl[l].exponent) && (|a.sgl[l].mantissa);
      s_den_b[l]  = (~|b.sgl[l].exponent) && (|b.sgl[l].mantissa);
      s_hit[l] = pred_hit(a.sgl[l].sign, b.sgl[l].sign,
                          63'({a.sgl[l].exponent, a.sgl[l].mantissa}),
                          63'({b.sgl[l].exponent, b.sgl[l].mantissa}),
                          s_nan_a[l] | s_nan_b[l], pred);
    end
    if (paired) begin
      res_d = {{32{s_hit[1]}}, {32{s_hit[0]}}};
      flags_d[FLAG_INVALID]  = ordered ? |(s_nan_a | s_nan_b) : |(s_snan_a | s_snan_b);
      flags_d[FLAG_DENORMAL] = |(s_den_a | s_den_b);
    end else begin
      res_d = {WORD_W{d_hit}};
      flags_d[FLAG_INVALID]  = ordered ? (d_nan_a | d_nan_b) : (d_snan_a | d_snan_b);
      flags_d[FLAG_DENORMAL] = d_den_a | d_den_b;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res   <= '0;
      flags <= '0;
    end else begin
      res   <= res_d;
      flags <= flags_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fpu_exception_report.sv
// retire exception report, masks the raised flags with the enables
// and encodes the lowest enabled flag as the exception code
// purely combinational on the registered second stage outputs
`default_nettype none

module fpu_exception_report import fpu_pkg::*; (
  input  logic [FLAG_W-1:0]     flags,
  input  logic [FLAG_W-1:0]     fp_enables,
  input  logic                  valid,
  input  logic [TAG_W-1:0]      tag,
  output logic                  exc_valid,
  output logic [FLAG_IDX_W-1:0] exc_code,
  output logic [TAG_W-1:0]      exc_tag
);

  logic [FLAG_W-1:0] masked;

  assign masked    = flags & fp_enables;
  assign exc_valid = valid && (|masked);
  assign exc_tag   = tag;

  // walk down so the lowest set index wins
  always_comb begin
    exc_code = '0;
    for (int i = FLAG_W - 1; i >= 0; i--) begin
      if (masked[i]) begin
        exc_code = FLAG_IDX_W'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/fpu_vector_unit.sv
// vector fp side unit, one issue port and a fixed two cycle pipeline
// stage 1 resolves operands and decodes, stage 2 executes
// results, flags and the exception report appear two edges after issue
`default_nettype none

module fpu_vector_unit import fpu_pkg::*; #(
  parameter int FWD_COUNT = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             issue_en,
  input  logic [OPC_W-1:0]                 issue_op,
  input  logic [TAG_W-1:0]                 issue_tag,
  input  logic [WORD_W-1:0]                op_a,
  input  logic [WORD_W-1:0]                op_b,
  input  logic [$clog2(FWD_COUNT + 1)-1:0] fwd_sel_a,
  input  logic [$clog2(FWD_COUNT + 1)-1:0] fwd_sel_b,
  input  logic                             fwd_late_a,
  input  logic                             fwd_late_b,
  input  logic [FWD_COUNT-1:0][WORD_W-1:0] fwd_bus,
  input  logic [FLAG_W-1:0]                fp_enables,
  output logic                             res_valid,
  output logic [WORD_W-1:0]                result,
  output logic [FLAG_W-1:0]                flags,
  output logic                             exc_valid,
  output logic [FLAG_IDX_W-1:0]            exc_code,
  output logic [TAG_W-1:0]                 exc_tag
);

  logic [WORD_W-1:0] opa_w, opb_w, lane_res, cmp_res;
  logic [FLAG_W-1:0] lane_flags, cmp_flags;
  fp_word_u          opa_q, opb_q;
  logic              dec_valid, cmp_paired, cmp_ordered;
  exec_class_e       dec_class, class_q2;
  logic [1:0]        logic_sel, perm_sel, cmp_pred;
  logic [TAG_W-1:0]  dec_tag, tag_q2;

  operand_forward #(.FWD_COUNT(FWD_COUNT)) fwd_a_i (
    .clk(clk), .rst(rst), .port_val(op_a), .sel(fwd_sel_a), .late(fwd_late_a),
    .fwd_bus(fwd_bus), .operand(opa_w)
  );

  operand_forward #(.FWD_COUNT(FWD_COUNT)) fwd_b_i (
    .clk(clk), .rst(rst), .port_val(op_b), .sel(fwd_sel_b), .late(fwd_late_b),
    .fwd_bus(fwd_bus), .operand(opb_w)
  );

  fpu_op_decode decode_i (
    .clk(clk), .rst(rst), .en(issue_en), .op(issue_op), .tag(issue_tag),
    .valid(dec_valid), .exec_class(dec_class), .logic_sel(logic_sel), .perm_sel(perm_sel),
    .cmp_pred(cmp_pred), .cmp_paired(cmp_paired), .cmp_ordered(cmp_ordered), .tag_q(dec_tag)
  );

  // resolved operands sit beside the decoded control in stage 1
  always_ff @(posedge clk) begin
    opa_q <= opa_w;
    opb_q <= opb_w;
  end

  fpu_lane_ops lane_i (
    .clk(clk), .rst(rst), .a(opa_q), .b(opb_q), .exec_class(dec_class),
    .logic_sel(logic_sel), .perm_sel(perm_sel), .res(lane_res), .flags(lane_flags)
  );

  fpu_compare cmp_i (
    .clk(clk), .rst(rst), .a(opa_q), .b(opb_q), .pred(cmp_pred), .paired(cmp_paired),
    .ordered(cmp_ordered), .res(cmp_res), .flags(cmp_flags)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      class_q2  <= CLASS_LOGIC;
    end else begin
      res_valid <= dec_valid;
      class_q2  <= dec_class;
    end
  end

  always_ff @(posedge clk) begin
    tag_q2 <= dec_tag;
  end

  assign result = (class_q2 == CLASS_COMPARE) ? cmp_res : lane_res;
  assign flags  = (class_q2 == CLASS_COMPARE) ? cmp_flags : lane_flags;

  fpu_exception_report report_i (
    .flags(flags), .fp_enables(fp_enables), .valid(res_valid), .tag(tag_q2),
    .exc_valid(exc_valid), .exc_code(exc_code), .exc_tag(exc_tag)
  );

endmodule

`default_nettype wire

// File: dv/fpu_vector_unit_tb.sv
// testbench for the vector fp side unit
// drives random operations every cycle and checks each result against a model
// that is built from the opcode, forwarding and flag rules of the unit
`default_nettype none

module fpu_vector_unit_tb import fpu_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FWD_COUNT   = 4;
  localparam int SEL_W       = $clog2(FWD_COUNT + 1);
  localparam int DRAIN_LIMIT = 20;

  typedef logic [FWD_COUNT-1:0][WORD_W-1:0] bus_t;
  typedef struct packed {
    logic              v;
    logic [WORD_W-1:0] res;
    logic [FLAG_W-1:0] flg;
    logic [TAG_W-1:0]  tag;
  } exp_t;

  logic clk, rst, issue_en, fwd_late_a, fwd_late_b;
  logic [OPC_W-1:0] issue_op;
  logic [TAG_W-1:0] issue_tag, exc_tag;
  logic [WORD_W-1:0] op_a, op_b, result;
  logic [SEL_W-1:0] fwd_sel_a, fwd_sel_b;
  bus_t fwd_bus;
  logic [FLAG_W-1:0] fp_enables, flags;
  logic res_valid, exc_valid;
  logic [FLAG_IDX_W-1:0] exc_code;

  integer seed;
  int errors, test_errors, checks, pending;
  exp_t exp_q[$];
  // model copy of the bus value currently driven and the enables on the port
  bus_t bus_m;
  logic [FLAG_W-1:0] en_now;

  fpu_vector_unit #(.FWD_COUNT(FWD_COUNT)) dut_i (
    .clk(clk), .rst(rst), .issue_en(issue_en), .issue_op(issue_op), .issue_tag(issue_tag),
    .op_a(op_a), .op_b(op_b), .fwd_sel_a(fwd_sel_a), .fwd_sel_b(fwd_sel_b),
    .fwd_late_a(fwd_late_a), .fwd_late_b(fwd_late_b), .fwd_bus(fwd_bus),
    .fp_enables(fp_enables), .res_valid(res_valid), .result(result), .flags(flags),
    .exc_valid(exc_valid), .exc_code(exc_code), .exc_tag(exc_tag)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [63:0] rnd64();
    return {$random(seed), $random(seed)};
  endfunction

  // random single with zeros, quiet and signalling NaNs, denormals and infinities
  function automatic logic [31:0] special_single();
    logic [31:0] r;
    r = $random(seed);
    case ($random(seed) & 7)
      0: return {r[31], 31'h0};
      1: return {r[31], 8'hff, 1'b1, r[21:0]};
      2: return {r[31], 8'hff, 1'b0, r[21:1], 1'b1};
      3: return {r[31], 8'h00, r[22:1], 1'b1};
      4: return {r[31], 8'hff, 23'h0};
      default: return r;
    endcase
  endfunction

  function automatic logic [63:0] special_double();
    logic [63:0] r;
    r = rnd64();
    case ($random(seed) & 7)
      0: return {r[63], 63'h0};
      1: return {r[63], 11'h7ff, 1'b1, r[50:0]};
      2: return {r[63], 11'h7ff, 1'b0, r[50:1], 1'b1};
      3: return {r[63], 11'h000, r[51:1], 1'b1};
      4: return {r[63], 11'h7ff, 52'h0};
      default: return r;
    endcase
  endfunction

  function automatic logic [63:0] resolve(input logic [SEL_W-1:0] sel, input logic late,
                                          input logic [63:0] port, input bus_t cur,
                                          input bus_t prev);
    if (sel == 0) return port;
    if (sel > FWD_COUNT) return 64'h0;
    return late ? prev[sel-1] : cur[sel-1];
  endfunction

  // one compare lane, returns {hit, invalid, denormal}
  // values are ordered through a signed key so that +0 and -0 meet at zero
  function automatic logic [2:0] lane_eval(input logic [63:0] x, input logic [63:0] y,
                                           input bit dbl, input int l,
                                           input logic [1:0] pred, input bit ordered);
    logic sx, sy, nx, ny, qx, qy, dx, dy, un, inv, hit;
    longint kx, ky;
    if (dbl) begin
      sx = x[63];
      sy = y[63];
      nx = (&x[62:52]) && (x[51:0] != 0);
      ny = (&y[62:52]) && (y[51:0] != 0);
      qx = x[51];
      qy = y[51];
      dx = (x[62:52] == 0) && (x[51:0] != 0);
      dy = (y[62:52] == 0) && (y[51:0] != 0);
      kx = {1'b0, x[62:0]};
      ky = {1'b0, y[62:0]};
    end else begin
      sx = x[32*l+31];
      sy = y[32*l+31];
      nx = (&x[32*l+23 +: 8]) && (x[32*l +: 23] != 0);
      ny = (&y[32*l+23 +: 8]) && (y[32*l +: 23] != 0);
      qx = x[32*l+22];
      qy = y[32*l+22];
      dx = (x[32*l+23 +: 8] == 0) && (x[32*l +: 23] != 0);
      dy = (y[32*l+23 +: 8] == 0) && (y[32*l +: 23] != 0);
      kx = {33'h0, x[32*l +: 31]};
      ky = {33'h0, y[32*l +: 31]};
    end
    if (sx) kx = -kx;
    if (sy) ky = -ky;
    un  = nx | ny;
    inv = ordered ? un : ((nx & ~qx) | (ny & ~qy));
    case (pred)
      2'd0:    hit = !un && (kx == ky);
      2'd1:    hit = !un && (kx < ky);
      2'd2:    hit = !un && (kx <= ky);
      default: hit = un;
    endcase
    return {hit, inv, dx | dy};
  endfunction

  task automatic model_op(input logic [5:0] op, input logic [63:0] a, input logic [63:0] b,
                          output logic [63:0] res, output logic [1:0] flg);
    logic [2:0] r0, r1;
    flg = 2'b00;
    if (op[3:2] == 2'b10) begin
      if (op[4]) begin
        r0 = lane_eval(a, b, 1'b0, 0, op[1:0], op[5]);
        r1 = lane_eval(a, b, 1'b0, 1, op[1:0], op[5]);
        res = {{32{r1[2]}}, {32{r0[2]}}};
        flg[FLAG_INVALID]  = r0[1] | r1[1];
        flg[FLAG_DENORMAL] = r0[0] | r1[0];
      end else begin
        r0 = lane_eval(a, b, 1'b1, 0, op[1:0], op[5]);
        res = {64{r0[2]}};
        flg[FLAG_INVALID]  = r0[1];
        flg[FLAG_DENORMAL] = r0[0];
      end
    end else begin
      case (op)
        OP_OR:      res = a | b;
        OP_XOR:     res = a ^ b;
        OP_ANDN:    res = a & ~b;
        OP_SWAP_S:  res = {a[31:0], a[63:32]};
        OP_DUP_S:   res = {b[31:0], b[31:0]};
        OP_MERGE_S: res = {a[63:32], b[31:0]};
        // and, and every unknown opcode
        default:    res = a & b;
      endcase
    end
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("** Error: %s = %h, expected %h", name, got, want);
    errors++;
    test_errors++;
  endtask

  task automatic check_out(input exp_t e);
    logic [1:0] masked;
    logic code_exp;
    masked = e.flg & en_now;
    code_exp = masked[FLAG_INVALID] ? 1'b0 : 1'b1;
    checks++;
    if (res_valid !== e.v) report_mismatch("res_valid", res_valid, e.v);
    if (e.v) begin
      pending--;
      if (result !== e.res) report_mismatch("result", result, e.res);
      if (flags !== e.flg) report_mismatch("flags", flags, e.flg);
      if (exc_valid !== (|masked)) report_mismatch("exc_valid", exc_valid, |masked);
      if ((|masked) && (exc_code !== code_exp)) report_mismatch("exc_code", exc_code, code_exp);
      if ((|masked) && (exc_tag !== e.tag)) report_mismatch("exc_tag", exc_tag, e.tag);
    end else if (exc_valid !== 1'b0) begin
      report_mismatch("exc_valid", exc_valid, 1'b0);
    end
  endtask

  // one clock cycle, new inputs after the rising edge and checks at the falling edge
  task automatic step(input logic en, input logic [5:0] op, input logic [5:0] tag,
                      input logic [63:0] a, input logic [63:0] b,
                      input logic [SEL_W-1:0] sa, input logic la,
                      input logic [SEL_W-1:0] sb, input logic lb, input logic [1:0] ena);
    bus_t nb;
    exp_t e;
    logic [63:0] ra, rb;
    @(posedge clk);
    for (int i = 0; i < FWD_COUNT; i++) begin
      nb[i] = rnd64();
    end
    // a late operand sees the bus value of the cycle before its issue
    ra = resolve(sa, la, a, nb, bus_m);
    rb = resolve(sb, lb, b, nb, bus_m);
    bus_m = nb;
    e.v = en;
    e.tag = tag;
    model_op(op, ra, rb, e.res, e.flg);
    issue_en   <= en;
    issue_op   <= op;
    issue_tag  <= tag;
    op_a       <= a;
    op_b       <= b;
    fwd_sel_a  <= sa;
    fwd_late_a <= la;
    fwd_sel_b  <= sb;
    fwd_late_b <= lb;
    fwd_bus    <= nb;
    fp_enables <= ena;
    en_now = ena;
    exp_q.push_back(e);
    if (en) pending++;
    @(negedge clk);
    // entry issued two drives ago is now at the outputs
    if (exp_q.size() == 3) check_out(exp_q.pop_front());
  endtask

  task automatic step_idle();
    step(1'b0, OP_AND, 6'h0, 64'h0, 64'h0, '0, 1'b0, '0, 1'b0, 2'b00);
  endtask

  task automatic finish_test(input string name);
    int cycles;
    cycles = 0;
    while (pending > 0 && cycles < DRAIN_LIMIT) begin
      step_idle();
      cycles++;
    end
    if (pending > 0) begin
      $display("timeout, %0d results still missing after %0d cycles", pending, cycles);
      errors++;
      test_errors++;
      pending = 0;
    end
    $display("test %s done, %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  initial begin
    logic [31:0] r;
    logic [63:0] a, b;
    logic [5:0] op;
    seed = 32'hdbdf_0f79;
    errors = 0;
    test_errors = 0;
    checks = 0;
    pending = 0;
    bus_m = '0;
    en_now = '0;
    rst = 1'b1;
    issue_en = 1'b0;
    issue_op = '0;
    issue_tag = '0;
    op_a = '0;
    op_b = '0;
    fwd_sel_a = '0;
    fwd_sel_b = '0;
    fwd_late_a = 1'b0;
    fwd_late_b = 1'b0;
    fwd_bus = '0;
    fp_enables = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 6; i++) begin
      step_idle();
      checks++;
      if (res_valid !== 1'b0) report_mismatch("res_valid", res_valid, 1'b0);
      if (exc_valid !== 1'b0) report_mismatch("exc_valid", exc_valid, 1'b0);
      if (flags !== '0) report_mismatch("flags", flags, 2'b00);
    end
    finish_test("reset");

    // opcode 7 is unknown and runs as an and
    for (int i = 0; i < 300; i++) begin
      op = 6'($random(seed) & 7);
      step(1'b1, op, 6'(i), rnd64(), rnd64(), '0, 1'b0, '0, 1'b0, 2'b11);
    end
    finish_test("logic_permute");

    // odd iterations forward a, even ones forward b, the other side is a zero port
    for (int i = 0; i < 300; i++) begin
      r = $random(seed);
      if (i[0]) begin
        step(r[8], OP_OR, 6'(i), rnd64(), 64'h0, SEL_W'(r[2:0]), r[3], '0, 1'b0, 2'b00);
      end else begin
        step(r[8], OP_OR, 6'(i), 64'h0, rnd64(), '0, 1'b0, SEL_W'(r[2:0]), r[3], 2'b00);
      end
    end
    finish_test("forwarding");

    for (int i = 0; i < 400; i++) begin
      r = $random(seed);
      op = {r[5], r[4], 2'b10, r[1:0]};
      a = op[4] ? {special_single(), special_single()} : special_double();
      b = op[4] ? {special_single(), special_single()} : special_double();
      if (r[7:6] == 2'b00) b = a;
      step(1'b1, op, 6'(i), a, b, '0, 1'b0, '0, 1'b0, 2'b00);
    end
    finish_test("compare");

    for (int i = 0; i < 400; i++) begin
      r = $random(seed);
      op = r[9] ? {r[5], r[4], 2'b10, r[1:0]} : {4'h0, r[1:0]};
      a = r[4] ? {special_single(), special_single()} : special_double();
      b = r[4] ? {special_single(), special_single()} : special_double();
      step(r[10] | r[11], op, 6'(r[17:12]), a, b, '0, 1'b0, '0, 1'b0, r[20:19]);
    end
    finish_test("exception_report");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
verilog/fpu_pkg.sv
verilog/operand_forward.sv
verilog/fpu_op_decode.sv
verilog/fpu_lane_ops.sv
verilog/fpu_compare.sv
verilog/fpu_exception_report.sv
verilog/fpu_vector_unit.sv
dv/fpu_vector_unit_tb.sv

// File: Bender.yml
package:
  name: fpu_vector_unit

sources:
  - verilog/fpu_pkg.sv
  - verilog/operand_forward.sv
  - verilog/fpu_op_decode.sv
  - verilog/fpu_lane_ops.sv
  - verilog/fpu_compare.sv
  - verilog/fpu_exception_report.sv
  - verilog/fpu_vector_unit.sv
  - target: test
    files:
      - dv/fpu_vector_unit_tb.sv
